//--- bench/uart_string_stim.txt
// columns are mode count expect exp_len offset bad_stop and then count data bytes
// mode 00 is loopback and 01 is raw serial, ff in the mode column ends the list
// expect 01 means an error, bad_stop is the raw byte sent with a low stop bit or ff
// loopback strings of length 5, 32, 1 and 0
00 05 00 05 00 ff 48 65 6c 6c 6f
00 20 00 20 00 ff 30 31 32 33 34 35 36 37 38 39 3a 3b 3c 3d 3e 3f 40 41 42 43 44 45 46 47 48 49 4a 4b 4c 4d 4e 4f
00 01 00 01 00 ff 5a
00 00 00 00 00 ff
// stray bytes before a good frame
01 0a 00 03 05 ff 41 42 43 26 26 78 79 7a 26 26
// non-mark after the first mark
01 04 01 00 00 ff 26 78 79 7a
// non-mark after the closing mark
01 06 01 00 00 ff 26 26 61 62 26 78
// 33 content bytes
01 23 01 00 00 ff 26 26 40 41 42 43 44 45 46 47 48 49 4a 4b 4c 4d 4e 4f 50 51 52 53 54 55 56 57 58 59 5a 5b 5c 5d 5e 5f 60
// low stop bit inside a frame, then a good frame
01 04 01 00 00 03 26 26 61 62
01 09 00 05 02 ff 26 26 68 65 6c 6c 6f 26 26
ff

//--- verilog.f
+incdir+include
logic/uart_pkg.sv
logic/byte_link_if.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/frame_tx.sv
logic/frame_rx.sv
logic/uart_string_top.sv
bench/tb_uart_string.sv

//--- run_sim.sh
#!/bin/sh
# build and run the UART string transceiver testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
	--top-module tb_uart_string \
	-f verilog.f \
	--Mdir obj_dir -o tb_uart_string
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_uart_string > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -q "RESULT: FAIL" "$LOG"; then
	exit 1
fi
exit 0

//--- bench/tb_uart_string.sv
// testbench for the UART string transceiver
// test cases come from bench/uart_string_stim.txt, so run from the project root
// loopback cases route uart_tx_port back into uart_rx_port
`include "uart_macros.svh"

module tb_uart_string;

	import uart_pkg::*;

	localparam int CPB       = `UART_CLKS_PER_BIT;
	localparam int CHAR_CLKS = 11 * CPB;
	localparam int STIM_SIZE = 1024;

	logic       sys_clk;
	logic       sys_rst_n;
	str_buf_t   tx_string;
	str_len_t   tx_length;
	logic       tx_req;
	logic       tx_busy;
	logic       tx_done;
	str_buf_t   rx_string;
	str_len_t   rx_length;
	logic       rx_busy;
	logic       rx_done;
	logic       rx_err;
	logic       uart_rx_port;
	logic       uart_tx_port;

	// bench side of the serial line
	logic       loop_sel;
	logic       ser_line;

	logic [7:0] stim_mem [0:STIM_SIZE-1];

	int errors       = 0;
	int timeouts     = 0;
	int cases        = 0;
	int seed         = 32'h73185201;
	int rx_done_seen = 0;
	int rx_err_seen  = 0;
	int tx_done_seen = 0;
	int rx_busy_seen = 0;

	assign uart_rx_port = loop_sel ? uart_tx_port : ser_line;

	uart_string_top u_dut (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.tx_string    (tx_string),
		.tx_length    (tx_length),
		.tx_req       (tx_req),
		.tx_busy      (tx_busy),
		.tx_done      (tx_done),
		.rx_string    (rx_string),
		.rx_length    (rx_length),
		.rx_busy      (rx_busy),
		.rx_done      (rx_done),
		.rx_err       (rx_err),
		.uart_rx_port (uart_rx_port),
		.uart_tx_port (uart_tx_port)
	);

	initial begin
		sys_clk = 1'b0;
		forever #2 sys_clk = ~sys_clk;
	end

	// pulse counters, sampled mid-cycle
	always @(negedge sys_clk) begin
		if (sys_rst_n) begin
			if (rx_done) begin
				rx_done_seen++;
			end
			if (rx_err) begin
				rx_err_seen++;
			end
			if (tx_done) begin
				tx_done_seen++;
			end
			if (rx_busy) begin
				rx_busy_seen++;
			end
		end
	end

	task automatic wait_cycles(input int n);
		repeat (n) begin
			@(posedge sys_clk);
			#1;
		end
	endtask

	task automatic check_level(input string name, input logic got, input logic exp);
		assert (got === exp) else begin
			errors++;
			$display("Error at %0t: %s expected %b got %b", $time, name, exp, got);
		end
	endtask

	task automatic compare_vector(input string name, input logic [255:0] got,
		input logic [255:0] exp);
		assert (got === exp) else begin
			errors++;
			$display("Error at %0t: %s expected %0h got %0h", $time, name, exp, got);
		end
	endtask

	task automatic require_true(input logic cond, input string msg);
		assert (cond) else begin
			errors++;
			$display("Error at %0t: %s", $time, msg);
		end
	endtask

	task automatic report_timeout(input string what);
		timeouts++;
		$display("Timeout at %0t: %s did not arrive in time", $time, what);
	endtask

	task automatic hold_line(input logic level, input int cycles);
		ser_line = level;
		wait_cycles(cycles);
	endtask

	// 8N1 character plus one idle bit, stop level chosen by the caller
	task automatic send_serial_byte(input logic [7:0] data, input logic stop_level);
		logic [7:0] sh;
		int         i;
		sh = data;
		hold_line(1'b0, CPB);
		for (i = 0; i < 8; i++) begin
			hold_line(sh[0], CPB);
			sh = {1'b0, sh[7:1]};
		end
		hold_line(stop_level, CPB);
		hold_line(1'b1, CPB);
	endtask

	task automatic run_loopback(input int len, input int p);
		str_buf_t   exp_str;
		logic [4:0] bi;
		int         i;
		int         cyc;
		int         d0;
		int         e0;
		int         t0;
		int         b0;
		exp_str = '0;
		for (i = 0; i < len; i++) begin
			bi = 5'(i);
			exp_str[bi] = stim_mem[p + i];
		end
		d0 = rx_done_seen;
		e0 = rx_err_seen;
		t0 = tx_done_seen;
		b0 = rx_busy_seen;
		loop_sel  = 1'b1;
		tx_string = exp_str;
		tx_length = 6'(len);
		tx_req    = 1'b1;
		wait_cycles(1);
		tx_req = 1'b0;
		check_level("tx_busy", tx_busy, 1'b1);
		// the framer holds its own copy now
		tx_string = ~exp_str;
		tx_length = '0;
		wait_cycles(3);
		// a request while busy must start nothing
		tx_req = 1'b1;
		wait_cycles(1);
		tx_req = 1'b0;
		cyc = 0;
		while (!tx_done && cyc < (len + 6) * CHAR_CLKS) begin
			check_level("tx_busy", tx_busy, 1'b1);
			wait_cycles(1);
			cyc++;
		end
		if (!tx_done) begin
			report_timeout("tx_done");
		end else begin
			check_level("tx_busy", tx_busy, 1'b0);
		end
		cyc = 0;
		while (rx_done_seen == d0 && cyc < 4 * CHAR_CLKS) begin
			wait_cycles(1);
			cyc++;
		end
		if (rx_done_seen == d0) begin
			report_timeout("rx_done");
		end
		// quiet period where an extra frame would show up
		for (cyc = 0; cyc < 3 * CHAR_CLKS; cyc++) begin
			check_level("tx_busy", tx_busy, 1'b0);
			wait_cycles(1);
		end
		compare_vector("tx_done count", 256'(tx_done_seen - t0), 256'(1));
		compare_vector("rx_done count", 256'(rx_done_seen - d0), 256'(1));
		compare_vector("rx_err count", 256'(rx_err_seen - e0), 256'(0));
		compare_vector("rx_length", 256'(rx_length), 256'(len));
		compare_vector("rx_string", rx_string, exp_str);
		require_true(rx_busy_seen > b0, "rx_busy never went high during the frame");
		check_level("rx_busy", rx_busy, 1'b0);
	endtask

	task automatic run_raw(input int count, input int p, input int bad_idx,
		input int expect_err, input int exp_len, input int off);
		str_buf_t   exp_str;
		str_buf_t   prev_str;
		str_len_t   prev_len;
		logic [4:0] bi;
		int         i;
		int         cyc;
		int         d0;
		int         e0;
		int         b0;
		exp_str = '0;
		for (i = 0; i < exp_len; i++) begin
			bi = 5'(i);
			exp_str[bi] = stim_mem[p + off + i];
		end
		prev_str = rx_string;
		prev_len = rx_length;
		d0       = rx_done_seen;
		e0       = rx_err_seen;
		b0       = rx_busy_seen;
		loop_sel = 1'b0;
		for (i = 0; i < count; i++) begin
			send_serial_byte(stim_mem[p + i], (i == bad_idx) ? 1'b0 : 1'b1);
		end
		cyc = 0;
		while (rx_done_seen == d0 && rx_err_seen == e0 && cyc < 4 * CHAR_CLKS) begin
			wait_cycles(1);
			cyc++;
		end
		if (rx_done_seen == d0 && rx_err_seen == e0) begin
			report_timeout("rx_done or rx_err");
		end
		wait_cycles(2 * CHAR_CLKS);
		if (expect_err != 0) begin
			compare_vector("rx_err count", 256'(rx_err_seen - e0), 256'(1));
			compare_vector("rx_done count", 256'(rx_done_seen - d0), 256'(0));
			compare_vector("rx_length", 256'(rx_length), 256'(prev_len));
			compare_vector("rx_string", rx_string, prev_str);
		end else begin
			compare_vector("rx_err count", 256'(rx_err_seen - e0), 256'(0));
			compare_vector("rx_done count", 256'(rx_done_seen - d0), 256'(1));
			compare_vector("rx_length", 256'(rx_length), 256'(exp_len));
			compare_vector("rx_string", rx_string, exp_str);
			require_true(rx_busy_seen > b0, "rx_busy never went high during the frame");
		end
		check_level("rx_busy", rx_busy, 1'b0);
	endtask

	initial begin
		int ptr;
		int mode;
		int count;
		int expect_err;
		int exp_len;
		int off;
		int bad_idx;
		int rnd;
		sys_rst_n = 1'b0;
		tx_string = '0;
		tx_length = '0;
		tx_req    = 1'b0;
		loop_sel  = 1'b0;
		ser_line  = 1'b1;
		$readmemh("bench/uart_string_stim.txt", stim_mem);
		repeat (5) @(posedge sys_clk);
		#1;
		sys_rst_n = 1'b1;
		wait_cycles(1);

		// idle outputs straight after reset
		check_level("uart_tx_port", uart_tx_port, 1'b1);
		check_level("tx_busy", tx_busy, 1'b0);
		check_level("tx_done", tx_done, 1'b0);
		check_level("rx_busy", rx_busy, 1'b0);
		check_level("rx_done", rx_done, 1'b0);
		check_level("rx_err", rx_err, 1'b0);
		compare_vector("rx_string", rx_string, 256'(0));
		compare_vector("rx_length", 256'(rx_length), 256'(0));

		ptr = 0;
		while (ptr + 6 <= STIM_SIZE && stim_mem[ptr] != 8'hff) begin
			mode       = int'(stim_mem[ptr]);
			count      = int'(stim_mem[ptr + 1]);
			expect_err = int'(stim_mem[ptr + 2]);
			exp_len    = int'(stim_mem[ptr + 3]);
			off        = int'(stim_mem[ptr + 4]);
			bad_idx    = int'(stim_mem[ptr + 5]);
			if (mode == 0) begin
				run_loopback(count, ptr + 6);
			end else if (mode == 1) begin
				run_raw(count, ptr + 6, bad_idx, expect_err, exp_len, off);
			end else begin
				require_true(1'b0, "unknown test mode in the stimulus file");
				break;
			end
			ptr = ptr + 6 + count;
			cases++;
			rnd = $random(seed);
			wait_cycles(8 + (rnd & 31));
		end

		require_true(cases > 0, "no test cases were read from the stimulus file");
		$display("summary: %0d cases, %0d errors, %0d timeouts", cases, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- logic/uart_string_top.sv
// UART string transceiver, "&&content&&" frames in both directions
// transmit and receive paths run independently of each other
module uart_string_top (
	input  logic                sys_clk,
	input  logic                sys_rst_n,

	input  uart_pkg::str_buf_t  tx_string,
	input  uart_pkg::str_len_t  tx_length,
	input  logic                tx_req,
	output logic                tx_busy,
	output logic                tx_done,

	output uart_pkg::str_buf_t  rx_string,
	output uart_pkg::str_len_t  rx_length,
	output logic                rx_busy,
	output logic                rx_done,
	output logic                rx_err,

	input  logic                uart_rx_port,
	output logic                uart_tx_port
);

	byte_link_if link ();

	// transmit path
	frame_tx u_frame_tx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_string (tx_string),
		.tx_length (tx_length),
		.tx_req    (tx_req),
		.tx_busy   (tx_busy),
		.tx_done   (tx_done),
		.link      (link.tx_framer)
	);

	uart_tx u_uart_tx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.link      (link.tx_phy),
		.txd       (uart_tx_port)
	);

	// receive path
	uart_rx u_uart_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rxd       (uart_rx_port),
		.link      (link.rx_phy)
	);

	frame_rx u_frame_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.link      (link.rx_framer),
		.rx_string (rx_string),
		.rx_length (rx_length),
		.rx_busy   (rx_busy),
		.rx_done   (rx_done),
		.rx_err    (rx_err)
	);

endmodule

//--- logic/frame_rx.sv
// receives "&&content&&" frames from the byte stream
// bytes other than '&' are skipped while hunting for a frame
// rx_string and rx_length change only on a complete frame
`include "uart_macros.svh"

module frame_rx (
	input  logic                sys_clk,
	input  logic                sys_rst_n,
	byte_link_if.rx_framer      link,
	output uart_pkg::str_buf_t  rx_string,
	output uart_pkg::str_len_t  rx_length,
	output logic                rx_busy,
	output logic                rx_done,
	output logic                rx_err
);

	import uart_pkg::*;

	frx_state_t state;
	str_buf_t   wbuf;
	str_len_t   cnt;
	logic       is_mark;
	logic       bad;
	logic       store;
	logic       start_content;

	assign is_mark = (link.rx_data == `FRAME_MARK);

	// line error mid-frame, wrong mark, or content too long
	always_comb begin
		bad = 1'b0;
		if (state != FRX_HUNT && link.rx_err) begin
			bad = 1'b1;
		end else if (link.rx_vld) begin
			case (state)
				FRX_MARK2:   bad = !is_mark;
				FRX_CONTENT: bad = !is_mark && (cnt == str_len_t'(`STR_MAX_BYTES));
				FRX_CLOSE:   bad = !is_mark;
				default:     bad = 1'b0;
			endcase
		end
	end

	assign start_content = link.rx_vld && is_mark && (state == FRX_MARK2);
	assign store         = link.rx_vld && !is_mark && !bad && (state == FRX_CONTENT);

	assign rx_busy = (state != FRX_HUNT);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state     <= FRX_HUNT;
			cnt       <= '0;
			rx_done   <= 1'b0;
			rx_err    <= 1'b0;
			rx_string <= '0;
			rx_length <= '0;
		end else begin
			rx_done <= 1'b0;
			rx_err  <= bad;
			if (bad) begin
				state <= FRX_HUNT;
			end else if (link.rx_vld) begin
				case (state)
					FRX_HUNT: begin
						if (is_mark) begin
							state <= FRX_MARK2;
						end
					end
					FRX_MARK2: begin
						state <= FRX_CONTENT;
						cnt   <= '0;
					end
					FRX_CONTENT: begin
						if (is_mark) begin
							state <= FRX_CLOSE;
						end else begin
							cnt <= cnt + 6'd1;
						end
					end
					FRX_CLOSE: begin
						// frame complete, publish it
						state     <= FRX_HUNT;
						rx_done   <= 1'b1;
						rx_string <= wbuf;
						rx_length <= cnt;
					end
					default: state <= FRX_HUNT;
				endcase
			end
		end
	end

	// working buffer, cleared at frame start so unused bytes read zero
	always_ff @(posedge sys_clk) begin
		if (start_content) begin
			wbuf <= '0;
		end else if (store) begin
			wbuf[cnt[4:0]] <= link.rx_data;
		end
	end

endmodule

//--- logic/frame_tx.sv
// sends "&&", tx_length content bytes, then "&&" for each accepted request
// string and length are captured at the request and may change afterwards
// content must not contain '&', requests while busy are ignored
`include "uart_macros.svh"

module frame_tx (
	input  logic                sys_clk,
	input  logic                sys_rst_n,
	input  uart_pkg::str_buf_t  tx_string,
	input  uart_pkg::str_len_t  tx_length,
	input  logic                tx_req,
	output logic                tx_busy,
	output logic                tx_done,
	byte_link_if.tx_framer      link
);

	import uart_pkg::*;

	ftx_state_t state;
	str_buf_t   str_q;
	str_len_t   len_q;
	str_len_t   idx;
	logic       load;
	logic       send_next;
	logic       send_content;
	logic [7:0] next_byte;

	assign load      = (state == FTX_IDLE) && tx_req;
	assign send_next = link.tx_done && (state != FTX_IDLE) && (state != FTX_MARK4);

	// content byte follows the second mark and each content byte until idx hits length
	assign send_content = ((state == FTX_MARK2) || (state == FTX_CONTENT)) && (idx != len_q);
	assign next_byte    = send_content ? str_q[idx[4:0]] : `FRAME_MARK;

	assign tx_busy = (state != FTX_IDLE);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state       <= FTX_IDLE;
			idx         <= '0;
			link.tx_req <= 1'b0;
			tx_done     <= 1'b0;
		end else begin
			link.tx_req <= load | send_next;
			tx_done     <= 1'b0;
			if (load) begin
				state <= FTX_MARK1;
				idx   <= '0;
			end else if (link.tx_done) begin
				if (send_content) begin
					idx <= idx + 6'd1;
				end
				case (state)
					FTX_MARK1:   state <= FTX_MARK2;
					FTX_MARK2:   state <= send_content ? FTX_CONTENT : FTX_MARK3;
					FTX_CONTENT: state <= send_content ? FTX_CONTENT : FTX_MARK3;
					FTX_MARK3:   state <= FTX_MARK4;
					FTX_MARK4: begin
						state   <= FTX_IDLE;
						tx_done <= 1'b1;
					end
					default:     state <= FTX_IDLE;
				endcase
			end
		end
	end

	// captured request and the byte on offer to the UART
	always_ff @(posedge sys_clk) begin
		if (load) begin
			str_q        <= tx_string;
			len_q        <= tx_length;
			link.tx_data <= `FRAME_MARK;
		end else if (send_next) begin
			link.tx_data <= next_byte;
		end
	end

endmodule

//--- logic/uart_rx.sv
// 8N1 byte receiver, one stop bit checked at its middle
// start bit is re-checked at half a bit time, a high line there is a glitch
// a low stop bit gives rx_err instead of rx_vld
`include "uart_macros.svh"

module uart_rx (
	input  logic         sys_clk,
	input  logic         sys_rst_n,
	input  logic         rxd,
	byte_link_if.rx_phy  link
);

	localparam int CPB   = `UART_CLKS_PER_BIT;
	localparam int HALF  = CPB / 2;
	localparam int CNT_W = $clog2(CPB);

	logic             rxd_meta;
	logic             rxd_sync;
	logic             rxd_prev;
	logic             fall;
	logic             active;
	logic [CNT_W-1:0] clk_cnt;
	logic [3:0]       bit_idx;
	logic [7:0]       data_sh;

	// two-flop synchronizer plus edge history
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
			rxd_prev <= 1'b1;
		end else begin
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
			rxd_prev <= rxd_sync;
		end
	end

	assign fall = rxd_prev & ~rxd_sync;

	// bit_idx 0 is the start bit, 1..8 data, 9 stop
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			active      <= 1'b0;
			clk_cnt     <= '0;
			bit_idx     <= '0;
			link.rx_vld <= 1'b0;
			link.rx_err <= 1'b0;
		end else begin
			link.rx_vld <= 1'b0;
			link.rx_err <= 1'b0;
			if (!active) begin
				if (fall) begin
					active  <= 1'b1;
					clk_cnt <= '0;
					bit_idx <= '0;
				end
			end else if (bit_idx == 4'd0) begin
				if (clk_cnt == CNT_W'(HALF - 1)) begin
					clk_cnt <= '0;
					if (rxd_sync) begin
						active <= 1'b0;
					end else begin
						bit_idx <= 4'd1;
					end
				end else begin
					clk_cnt <= clk_cnt + CNT_W'(1);
				end
			end else if (clk_cnt == CNT_W'(CPB - 1)) begin
				// mid-bit sample point
				clk_cnt <= '0;
				if (bit_idx == 4'd9) begin
					active      <= 1'b0;
					link.rx_vld <= rxd_sync;
					link.rx_err <= ~rxd_sync;
				end else begin
					bit_idx <= bit_idx + 4'd1;
				end
			end else begin
				clk_cnt <= clk_cnt + CNT_W'(1);
			end
		end
	end

	// LSB arrives first, so shift in from the top
	always_ff @(posedge sys_clk) begin
		if (active && bit_idx != 4'd0 && bit_idx != 4'd9 && clk_cnt == CNT_W'(CPB - 1)) begin
			data_sh <= {rxd_sync, data_sh[7:1]};
		end
	end

	assign link.rx_data = data_sh;

endmodule

//--- logic/uart_tx.sv
// 8N1 byte transmitter with one extra idle guard bit per byte
// a character is 11 bit times: start, 8 data LSB first, stop, guard
// requests arriving while a character is on the line are dropped
`include "uart_macros.svh"

module uart_tx (
	input  logic         sys_clk,
	input  logic         sys_rst_n,
	byte_link_if.tx_phy  link,
	output logic         txd
);

	localparam int CPB   = `UART_CLKS_PER_BIT;
	localparam int CNT_W = $clog2(CPB);

	logic             busy;
	logic [CNT_W-1:0] clk_cnt;
	logic [3:0]       bit_idx;
	logic [10:0]      shreg;
	logic             bit_end;

	assign bit_end = (clk_cnt == CNT_W'(CPB - 1));

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			busy         <= 1'b0;
			clk_cnt      <= '0;
			bit_idx      <= '0;
			txd          <= 1'b1;
			link.tx_done <= 1'b0;
		end else begin
			link.tx_done <= 1'b0;
			if (!busy) begin
				if (link.tx_req) begin
					// start bit goes out from the next cycle
					busy    <= 1'b1;
					clk_cnt <= '0;
					bit_idx <= '0;
					txd     <= 1'b0;
				end
			end else if (bit_end) begin
				clk_cnt <= '0;
				if (bit_idx == 4'd10) begin
					busy         <= 1'b0;
					txd          <= 1'b1;
					link.tx_done <= 1'b1;
				end else begin
					bit_idx <= bit_idx + 4'd1;
					txd     <= shreg[1];
				end
			end else begin
				clk_cnt <= clk_cnt + CNT_W'(1);
			end
		end
	end

	// character shifter, bit 0 is the one on the line
	always_ff @(posedge sys_clk) begin
		if (!busy && link.tx_req) begin
			shreg <= {2'b11, link.tx_data, 1'b0};
		end else if (busy && bit_end) begin
			shreg <= {1'b1, shreg[10:1]};
		end
	end

endmodule

//--- logic/byte_link_if.sv
// byte-level link between the framers and the bit-level UART
// tx_req is a one-cycle strobe with tx_data valid in the same cycle
// receive side has no back-pressure
interface byte_link_if;

	// transmit direction
	logic [7:0] tx_data;
	logic       tx_req;
	logic       tx_done;

	// receive direction
	logic [7:0] rx_data;
	logic       rx_vld;
	logic       rx_err;

	modport tx_framer (
		output tx_data,
		output tx_req,
		input  tx_done
	);

	modport tx_phy (
		input  tx_data,
		input  tx_req,
		output tx_done
	);

	modport rx_phy (
		output rx_data,
		output rx_vld,
		output rx_err
	);

	modport rx_framer (
		input  rx_data,
		input  rx_vld,
		input  rx_err
	);

endinterface

//--- logic/uart_pkg.sv
// types shared by the framers and the top level
// string byte 0 sits in bits [7:0] and goes on the line first
`include "uart_macros.svh"

package uart_pkg;

	// content buffer, one byte per element
	typedef logic [`STR_MAX_BYTES-1:0][7:0] str_buf_t;

	// content length, 0 to STR_MAX_BYTES
	typedef logic [5:0] str_len_t;

	// transmit framer
	typedef enum logic [2:0] {
		FTX_IDLE,
		FTX_MARK1,
		FTX_MARK2,
		FTX_CONTENT,
		FTX_MARK3,
		FTX_MARK4
	} ftx_state_t;

	// receive framer
	typedef enum logic [1:0] {
		FRX_HUNT,
		FRX_MARK2,
		FRX_CONTENT,
		FRX_CLOSE
	} frx_state_t;

endpackage

//--- include/uart_macros.svh
// shared build-time constants for the UART string transceiver
// baud rate is given directly in system clocks per bit
// clocks per bit must be even and at least 4
`ifndef UART_MACROS_SVH
`define UART_MACROS_SVH

// system clocks per serial bit
`define UART_CLKS_PER_BIT 8

// largest frame content in bytes, content length field is 6 bits
`define STR_MAX_BYTES 32

// frame delimiter, ASCII '&'
`define FRAME_MARK 8'h26

`endif
